// File: include/midi_consts.svh
`ifndef MIDI_CONSTS_SVH
`define MIDI_CONSTS_SVH

// polyphony of the synth engine
`define MIDI_VOICES 8

// status nibbles, upper half of the status byte
`define MIDI_ST_NOTE_OFF 4'h8
`define MIDI_ST_NOTE_ON  4'h9
`define MIDI_ST_CTRL     4'hB
`define MIDI_ST_PRG      4'hC
`define MIDI_ST_PITCH    4'hE

// controller numbers
`define MIDI_CC_ALL_OFF  8'd123

// key table code for an unused voice
`define MIDI_KEY_EMPTY   8'hFF

`endif

// File: verilog/midi_pkg.sv
package midi_pkg;

    // one byte from the uart receiver, with its running status
    typedef struct packed {
        logic [7:0] status;
        logic [7:0] byte_nr;   // 1 = first data byte
        logic [7:0] data;
    } midi_byte_t;

    // channel message once all data bytes are in
    typedef struct packed {
        logic [3:0] kind;      // status nibble
        logic [7:0] d1;
        logic [7:0] d2;        // 0 for program change
    } midi_msg_t;

endpackage

// File: verilog/synth_pkg.sv
package synth_pkg;

    `include "midi_consts.svh"

    typedef logic [$clog2(`MIDI_VOICES)-1:0] voice_idx_t;

    // note on / note off report towards the synth engine
    typedef struct packed {
        voice_idx_t voice;
        logic [7:0] key;
        logic [7:0] vel_on;
        logic [7:0] vel_off;
    } note_event_t;

    // last values seen per command kind
    typedef struct packed {
        logic [7:0] ctrl_num;
        logic [7:0] ctrl_val;
        logic [7:0] prg;
        logic [7:0] pitch_lsb;
        logic [7:0] pitch_msb;
    } ctrl_event_t;

endpackage

// File: verilog/midi_msg_parser.sv
`timescale 1ns/1ps
`include "midi_consts.svh"

module midi_msg_parser import midi_pkg::*; (
    input  logic       CLOCK_25,
    input  logic       iRST_N,
    input  logic       byteready,
    input  midi_byte_t in_byte,
    input  logic [3:0] midi_ch,
    output midi_msg_t  msg,
    output logic       msg_valid
);

    midi_byte_t byte_r;
    logic       rdy_r;
    logic [3:0] kind;
    logic       two_byte;
    logic       is_prg;
    logic [3:0] held_kind;
    logic [7:0] held_d1;
    logic       have_d1;

    assign kind = byte_r.status[7:4];
    assign is_prg = (kind == `MIDI_ST_PRG);
    assign two_byte = (kind == `MIDI_ST_NOTE_OFF) || (kind == `MIDI_ST_NOTE_ON) ||
                      (kind == `MIDI_ST_CTRL) || (kind == `MIDI_ST_PITCH);

    // input stage, channel filter on the strobe
    always_ff @(posedge CLOCK_25) begin
        if (!iRST_N) begin
            rdy_r <= 1'b0;
        end else begin
            rdy_r <= byteready && (in_byte.status[3:0] == midi_ch);
        end
    end

    always_ff @(posedge CLOCK_25) begin
        byte_r <= in_byte;
    end

    // assembly stage
    always_ff @(posedge CLOCK_25) begin
        if (!iRST_N) begin
            msg_valid <= 1'b0;
            have_d1   <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            if (rdy_r) begin
                if (byte_r.byte_nr == 8'd1 && is_prg) begin
                    msg.kind  <= kind;
                    msg.d1    <= byte_r.data;
                    msg.d2    <= 8'h00;
                    msg_valid <= 1'b1;
                    have_d1   <= 1'b0;
                end else if (byte_r.byte_nr == 8'd1 && two_byte) begin
                    held_kind <= kind;     // restarts assembly, covers running status
                    held_d1   <= byte_r.data;
                    have_d1   <= 1'b1;
                end else if (byte_r.byte_nr == 8'd2 && have_d1 && kind == held_kind) begin
                    msg.kind  <= held_kind;
                    msg.d1    <= held_d1;
                    msg.d2    <= byte_r.data;
                    msg_valid <= 1'b1;
                    have_d1   <= 1'b0;
                end else begin
                    have_d1   <= 1'b0;     // stray byte or unused status
                end
            end
        end
    end

endmodule

// File: verilog/voice_allocator.sv
`timescale 1ns/1ps
`include "midi_consts.svh"

module voice_allocator import midi_pkg::*, synth_pkg::*; (
    input  logic                    CLOCK_25,
    input  logic                    iRST_N,
    input  midi_msg_t               msg,
    input  logic                    msg_valid,
    input  logic [`MIDI_VOICES-1:0] voice_free,
    output logic [`MIDI_VOICES-1:0] keys_on,
    output logic                    note_on,
    output logic                    note_off,
    output note_event_t             note_ev,
    output logic [3:0]              active_keys,
    output logic                    off_note_error
);

    logic [7:0] key_val [`MIDI_VOICES];
    voice_idx_t age_q [`MIDI_VOICES];   // [0] is the oldest started voice

    logic       is_on;
    logic       is_off;
    logic       is_all_off;
    logic       has_free;
    logic       has_off;
    voice_idx_t free_voice;
    voice_idx_t off_voice;
    voice_idx_t new_voice;
    logic       hit;
    voice_idx_t hit_voice;
    logic [2:0] hit_pos;

    assign is_on = (msg.kind == `MIDI_ST_NOTE_ON) && (msg.d2 != 8'h00);
    assign is_off = (msg.kind == `MIDI_ST_NOTE_OFF) ||
                    ((msg.kind == `MIDI_ST_NOTE_ON) && (msg.d2 == 8'h00));
    assign is_all_off = (msg.kind == `MIDI_ST_CTRL) && (msg.d1 == `MIDI_CC_ALL_OFF);

    // lowest-index search, loops run downwards so the last hit wins
    always_comb begin
        has_free   = 1'b0;
        free_voice = '0;
        has_off    = 1'b0;
        off_voice  = '0;
        hit        = 1'b0;
        hit_voice  = '0;
        for (int i = `MIDI_VOICES - 1; i >= 0; i--) begin
            if (!keys_on[i] && voice_free[i]) begin
                has_free   = 1'b1;
                free_voice = voice_idx_t'(i);
            end
            if (!keys_on[i]) begin
                has_off   = 1'b1;
                off_voice = voice_idx_t'(i);
            end
            if (keys_on[i] && key_val[i] == msg.d1) begin
                hit       = 1'b1;
                hit_voice = voice_idx_t'(i);
            end
        end
    end

    assign new_voice = has_free ? free_voice : (has_off ? off_voice : age_q[0]);

    // where the released voice sits in the age queue
    always_comb begin
        hit_pos = '0;
        for (int j = `MIDI_VOICES - 1; j >= 0; j--) begin
            if (j < active_keys && age_q[j] == hit_voice) begin
                hit_pos = 3'(j);
            end
        end
    end

    always_ff @(posedge CLOCK_25) begin
        if (!iRST_N) begin
            keys_on        <= '0;
            note_on        <= 1'b0;
            note_off       <= 1'b0;
            note_ev        <= '0;
            active_keys    <= '0;
            off_note_error <= 1'b0;
            for (int i = 0; i < `MIDI_VOICES; i++) begin
                key_val[i] <= `MIDI_KEY_EMPTY;
                age_q[i]   <= '0;
            end
        end else begin
            note_on  <= 1'b0;
            note_off <= 1'b0;
            if (msg_valid && is_on) begin
                keys_on[new_voice] <= 1'b1;
                key_val[new_voice] <= msg.d1;
                note_ev.voice      <= new_voice;
                note_ev.key        <= msg.d1;
                note_ev.vel_on     <= msg.d2;
                note_on            <= 1'b1;
                if (has_off) begin
                    age_q[active_keys[2:0]] <= new_voice;
                    active_keys             <= active_keys + 4'd1;
                end else begin
                    // steal, oldest moves to the young end
                    for (int j = 0; j < `MIDI_VOICES - 1; j++) begin
                        age_q[j] <= age_q[j+1];
                    end
                    age_q[`MIDI_VOICES-1] <= new_voice;
                end
            end else if (msg_valid && is_off) begin
                if (hit) begin
                    keys_on[hit_voice] <= 1'b0;
                    key_val[hit_voice] <= `MIDI_KEY_EMPTY;
                    note_ev.voice      <= hit_voice;
                    note_ev.key        <= msg.d1;
                    note_ev.vel_off    <= msg.d2;
                    note_off           <= 1'b1;
                    active_keys        <= active_keys - 4'd1;
                    for (int j = 0; j < `MIDI_VOICES - 1; j++) begin
                        if (j >= hit_pos) age_q[j] <= age_q[j+1];
                    end
                end else begin
                    off_note_error <= 1'b1;   // sticky until all notes off
                end
            end else if (msg_valid && is_all_off) begin
                keys_on        <= '0;
                active_keys    <= '0;
                off_note_error <= 1'b0;
                for (int i = 0; i < `MIDI_VOICES; i++) begin
                    key_val[i] <= `MIDI_KEY_EMPTY;
                    age_q[i]   <= '0;
                end
            end
        end
    end

endmodule

// File: verilog/controller_decoder.sv
`timescale 1ns/1ps
`include "midi_consts.svh"

module controller_decoder import midi_pkg::*, synth_pkg::*; (
    input  logic        CLOCK_25,
    input  logic        iRST_N,
    input  midi_msg_t   msg,
    input  logic        msg_valid,
    output logic        ctrl_cmd,
    output logic        prg_ch_cmd,
    output logic        pitch_cmd,
    output ctrl_event_t ctrl_ev
);

    always_ff @(posedge CLOCK_25) begin
        if (!iRST_N) begin
            ctrl_cmd   <= 1'b0;
            prg_ch_cmd <= 1'b0;
            pitch_cmd  <= 1'b0;
            ctrl_ev    <= '0;
        end else begin
            ctrl_cmd   <= 1'b0;
            prg_ch_cmd <= 1'b0;
            pitch_cmd  <= 1'b0;
            if (msg_valid) begin
                case (msg.kind)
                    `MIDI_ST_CTRL: begin
                        if (msg.d1 != `MIDI_CC_ALL_OFF) begin   // 123 handled by allocator
                            ctrl_ev.ctrl_num <= msg.d1;
                            ctrl_ev.ctrl_val <= msg.d2;
                            ctrl_cmd         <= 1'b1;
                        end
                    end
                    `MIDI_ST_PRG: begin
                        ctrl_ev.prg <= msg.d1;
                        prg_ch_cmd  <= 1'b1;
                    end
                    `MIDI_ST_PITCH: begin
                        ctrl_ev.pitch_lsb <= msg.d1;
                        ctrl_ev.pitch_msb <= msg.d2;
                        pitch_cmd         <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: verilog/midi_decoder.sv
`timescale 1ns/1ps
`include "midi_consts.svh"

module midi_decoder import midi_pkg::*, synth_pkg::*; (
    input  logic                    CLOCK_25,
    input  logic                    iRST_N,
    input  logic                    byteready,
    input  midi_byte_t              in_byte,
    input  logic [3:0]              midi_ch,
    input  logic [`MIDI_VOICES-1:0] voice_free,
    output logic [`MIDI_VOICES-1:0] keys_on,
    output logic                    note_on,
    output logic                    note_off,
    output note_event_t             note_ev,
    output logic [3:0]              active_keys,
    output logic                    off_note_error,
    output logic                    ctrl_cmd,
    output logic                    prg_ch_cmd,
    output logic                    pitch_cmd,
    output ctrl_event_t             ctrl_ev
);

    midi_msg_t msg;
    logic      msg_valid;

    midi_msg_parser parser_inst (
        .CLOCK_25  (CLOCK_25),
        .iRST_N    (iRST_N),
        .byteready (byteready),
        .in_byte   (in_byte),
        .midi_ch   (midi_ch),
        .msg       (msg),
        .msg_valid (msg_valid)
    );

    voice_allocator voice_inst (
        .CLOCK_25       (CLOCK_25),
        .iRST_N         (iRST_N),
        .msg            (msg),
        .msg_valid      (msg_valid),
        .voice_free     (voice_free),
        .keys_on        (keys_on),
        .note_on        (note_on),
        .note_off       (note_off),
        .note_ev        (note_ev),
        .active_keys    (active_keys),
        .off_note_error (off_note_error)
    );

    controller_decoder ctrl_inst (
        .CLOCK_25   (CLOCK_25),
        .iRST_N     (iRST_N),
        .msg        (msg),
        .msg_valid  (msg_valid),
        .ctrl_cmd   (ctrl_cmd),
        .prg_ch_cmd (prg_ch_cmd),
        .pitch_cmd  (pitch_cmd),
        .ctrl_ev    (ctrl_ev)
    );

endmodule

// File: sim/tb_midi_decoder.sv
`timescale 1ns/1ps
`include "midi_consts.svh"

module tb_midi_decoder import midi_pkg::*, synth_pkg::*; ();

    logic        CLOCK_25;
    logic        iRST_N;
    logic        byteready;
    midi_byte_t  in_byte;
    logic [3:0]  midi_ch;
    logic [7:0]  voice_free;
    logic [7:0]  keys_on;
    logic        note_on, note_off, off_note_error;
    note_event_t note_ev;
    logic [3:0]  active_keys;
    logic        ctrl_cmd, prg_ch_cmd, pitch_cmd;
    ctrl_event_t ctrl_ev;

    string       rec_t[$];          // b, e or r
    string       rec_n[$];
    logic [7:0]  rec_a[$];
    logic [7:0]  rec_b[$];
    logic [7:0]  rec_c[$];
    int          limit;
    int          cycles = 0;
    logic [7:0]  lfsr = 8'd35;
    logic [7:0]  vf = 8'hFF;

    // reference model of the key table
    logic [7:0]  m_key [8];
    int          m_age [8];
    int          start_cnt = 0;
    int          pred_voice = 0;
    logic [7:0]  hold_d1 = 8'h00;

    midi_decoder dut (.*);

    initial begin
        CLOCK_25 = 1'b0;
        forever #50 CLOCK_25 = ~CLOCK_25;
    end

    always @(posedge CLOCK_25) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: the vectors did not finish within %0d cycles", limit);
            $display("Test FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);   // x^8+x^6+x^5+x^4+1
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    // free idle voice first, then any idle voice, then the oldest started
    task automatic model_msg(input logic [3:0] kind, input logic [7:0] d1, input logic [7:0] d2);
        int v;
        v = -1;
        if (kind == `MIDI_ST_NOTE_ON && d2 != 8'h00) begin
            for (int p = 0; p < 2 && v < 0; p++) begin
                for (int i = 7; i >= 0; i--) begin
                    if (m_key[i] == `MIDI_KEY_EMPTY && (vf[i] || p == 1)) v = i;
                end
            end
            if (v < 0) begin
                v = 0;
                for (int i = 1; i < 8; i++) begin
                    if (m_age[i] < m_age[v]) v = i;
                end
            end
            m_key[v] = d1;
            m_age[v] = start_cnt;
            start_cnt++;
            pred_voice = v;
        end else if (kind == `MIDI_ST_NOTE_OFF || kind == `MIDI_ST_NOTE_ON) begin
            for (int i = 7; i >= 0; i--) begin
                if (m_key[i] == d1) v = i;
            end
            if (v >= 0) m_key[v] = `MIDI_KEY_EMPTY;
        end else if (kind == `MIDI_ST_CTRL && d1 == `MIDI_CC_ALL_OFF) begin
            foreach (m_key[i]) m_key[i] = `MIDI_KEY_EMPTY;
        end
    endtask

    function automatic logic [7:0] actual(input string name);
        case (name)
            "keys_on", "model_keys":  return keys_on;
            "voice", "model_voice":   return 8'(note_ev.voice);
            "note_on":                return 8'(note_on);
            "note_off":               return 8'(note_off);
            "key":                    return note_ev.key;
            "vel_on":                 return note_ev.vel_on;
            "vel_off":                return note_ev.vel_off;
            "active_keys":            return 8'(active_keys);
            "off_note_error":         return 8'(off_note_error);
            "ctrl_cmd":               return 8'(ctrl_cmd);
            "prg_ch_cmd":             return 8'(prg_ch_cmd);
            "pitch_cmd":              return 8'(pitch_cmd);
            "ctrl_num":               return ctrl_ev.ctrl_num;
            "ctrl_val":               return ctrl_ev.ctrl_val;
            "prg":                    return ctrl_ev.prg;
            "pitch_lsb":              return ctrl_ev.pitch_lsb;
            "pitch_msb":              return ctrl_ev.pitch_msb;
            default:                  return 8'hxx;   // unknown name never matches
        endcase
    endfunction

    task automatic check(input string name, input logic [7:0] val);
        logic [7:0] want;
        logic [7:0] got;
        want = val;
        got = actual(name);
        if (name == "model_voice") want = 8'(pred_voice);
        if (name == "model_keys") begin
            foreach (m_key[i]) want[i] = (m_key[i] != `MIDI_KEY_EMPTY);
        end
        assert (got === want) else begin
            $display("error: time %0t signal %s expected %h actual %h", $time, name, want, got);
            $display("Test FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    initial begin
        int         fd;
        int         n;
        string      tok;
        string      name;
        logic [7:0] a, b, c, gap;
        logic       rand_mode;
        logic       after_check;
        logic       pending;
        iRST_N = 1'b0;
        byteready = 1'b0;
        in_byte = '0;
        midi_ch = 4'h3;
        voice_free = 8'hFF;
        rand_mode = 1'b0;
        after_check = 1'b1;
        pending = 1'b0;
        foreach (m_key[i]) m_key[i] = `MIDI_KEY_EMPTY;
        fd = $fopen("sim/midi_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/midi_vectors.txt");
            $display("Test FAILED");
            $fatal(1, "no vectors");
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            name = "";
            b = 8'h00;
            c = 8'h00;
            if (tok == "b") n = $fscanf(fd, "%h %h %h", a, b, c);
            else if (tok == "e") n = $fscanf(fd, "%s %h", name, a);
            else if (tok == "r") n = $fscanf(fd, "%h", a);
            else n = $fgets(name, fd);   // comment line
            if (tok == "b" || tok == "e" || tok == "r") begin
                if ((tok == "b" && n != 3) || (tok == "e" && n != 2) ||
                    (tok == "r" && n != 1)) begin
                    $display("malformed %s record in sim/midi_vectors.txt", tok);
                    $display("Test FAILED");
                    $fatal(1, "bad vector file");
                end
                rec_t.push_back(tok);
                rec_n.push_back(name);
                rec_a.push_back(a);
                rec_b.push_back(b);
                rec_c.push_back(c);
            end
        end
        $fclose(fd);
        limit = 20 * rec_t.size() + 100;

        repeat (10) @(posedge CLOCK_25);
        iRST_N <= 1'b1;
        foreach (rec_t[i]) begin
            if (rec_t[i] == "r") begin
                rand_mode = rec_a[i][0];
                vf = 8'hFF;
            end else if (rec_t[i] == "b") begin
                if (after_check) begin
                    take_bits(2, gap);   // idle gap before a new message
                    repeat (gap) @(posedge CLOCK_25);
                    if (rand_mode) take_bits(8, vf);
                end
                @(posedge CLOCK_25);
                byteready <= 1'b1;
                in_byte <= {rec_a[i], rec_b[i], rec_c[i]};
                voice_free <= vf;
                if (rec_a[i][3:0] == midi_ch && rec_b[i] == 8'd1) hold_d1 = rec_c[i];
                if (rec_a[i][3:0] == midi_ch && rec_b[i] == 8'd2) begin
                    model_msg(rec_a[i][7:4], hold_d1, rec_c[i]);
                end
                after_check = 1'b0;
                pending = 1'b1;
            end else begin
                if (pending) begin
                    @(posedge CLOCK_25);
                    byteready <= 1'b0;
                    repeat (2) @(posedge CLOCK_25);
                    @(negedge CLOCK_25);   // outputs settled 3 cycles after the last byte
                    pending = 1'b0;
                end
                check(rec_n[i], rec_a[i]);
                after_check = 1'b1;
            end
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: sim/midi_vectors.txt
# b status byte_nr data : one input byte per cycle, all hex, channel 3 is listened to
# e signal value : checked 3 cycles after the last byte ; r 1 or 0 : lfsr or all ones voice_free
r 1
b 93 1 3c
b 93 2 64
e model_voice 0
e model_keys 0
e note_on 1
e key 3c
e vel_on 64
b 93 1 40
b 93 2 50
e model_voice 0
e active_keys 2
r 0
b 83 1 3c
b 83 2 20
e note_off 1
e vel_off 20
e active_keys 1
b 83 1 11
b 83 2 00
e off_note_error 1
b 93 1 41
b 93 2 60
b 93 1 42
b 93 2 61
b 93 1 43
b 93 2 62
b 93 1 44
b 93 2 63
b 93 1 45
b 93 2 64
b 93 1 46
b 93 2 65
b 93 1 47
b 93 2 66
b 93 1 48
b 93 2 70
e model_voice 0
e active_keys 8
e off_note_error 1
b 93 1 48
b 93 2 00
e note_off 1
e active_keys 7
b b3 1 7b
b b3 2 00
e keys_on 00
e active_keys 0
e off_note_error 0
e ctrl_cmd 0
b b3 1 07
b b3 2 64
e ctrl_cmd 1
e ctrl_num 07
e ctrl_val 64
b c3 1 05
e prg_ch_cmd 1
e prg 05
b e3 1 12
b e3 2 40
e pitch_cmd 1
e pitch_lsb 12
e pitch_msb 40
b 95 1 3c
b 95 2 64
e note_on 0
e keys_on 00

// File: compile.f
+incdir+include
verilog/midi_pkg.sv
verilog/synth_pkg.sv
verilog/midi_msg_parser.sv
verilog/voice_allocator.sv
verilog/controller_decoder.sv
verilog/midi_decoder.sv
sim/tb_midi_decoder.sv

// File: run_sim.sh
#!/bin/sh
# build and run the midi decoder testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --timescale 1ns/1ps -f compile.f \
    --top-module tb_midi_decoder -o sim_midi
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi
out=$(./obj_dir/sim_midi)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if echo "$out" | grep -q "Test OK"; then
    exit 0
fi
exit 1
